/* flist.f */
+incdir+design
design/tcdmPkg.sv
design/rrArbiter.sv
design/tcdmBank.sv
design/bankInitFsm.sv
design/tcdmXbar.sv
design/tcdmCluster.sv
tests/tcdmCluster_props.sv
tests/tcdmChecker.sv
tests/tcdmClusterTb.sv

/* run.sh */
#!/bin/sh
# build and run the TCDM cluster testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tcdmClusterTb -f flist.f -o simv

./obj_dir/simv +verilator+error+limit+100 | tee sim.log

if grep -q "TEST FAILED" sim.log; then
  exit 1
fi
if ! grep -q "TEST PASSED" sim.log; then
  exit 1
fi

/* tests/tcdmClusterTb.sv */
// TCDM cluster testbench
// clock, reset, stimulus table and closing result

`timescale 1ns/1ps
`default_nettype none

`include "tcdm_defines.svh"

module tcdmClusterTb;

  localparam int NumIn     = `TCDM_NUM_IN;
  localparam int SweepRows = 2 ** `TCDM_BANK_ADDR_WIDTH;
  localparam int NumRows   = SweepRows + 8;
  localparam int MaxCycles = 16 + 8 + NumRows * 8 + 50;

  logic                        clk;
  logic                        reset;
  logic           [NumIn-1:0]  req;
  tcdmPkg::addr_t [NumIn-1:0]  addr;
  logic           [NumIn-1:0]  we;
  tcdmPkg::data_t [NumIn-1:0]  wdata;
  tcdmPkg::be_t   [NumIn-1:0]  be;
  logic           [NumIn-1:0]  gnt;
  logic           [NumIn-1:0]  vld;
  tcdmPkg::data_t [NumIn-1:0]  rdata;
  logic                        initDone;
  logic                        rowDone;
  int                          rowIdx;
  int                          errCount;
  int                          checkCount;
  int                          cycleCnt;

  // stimulus table, one entry per row, one slot per initiator
  logic [NumIn-1:0] tActive [NumRows];
  logic [NumIn-1:0] tWe [NumRows];
  tcdmPkg::addr_t   tAddr [NumRows][NumIn];
  tcdmPkg::data_t   tWdata [NumRows][NumIn];
  tcdmPkg::be_t     tBe [NumRows][NumIn];

  always #20 clk = ~clk;

  tcdmCluster dut0 (
    .clk_i      ( clk      ),
    .reset_i    ( reset    ),
    .req_i      ( req      ),
    .addr_i     ( addr     ),
    .we_i       ( we       ),
    .wdata_i    ( wdata    ),
    .be_i       ( be       ),
    .gnt_o      ( gnt      ),
    .vld_o      ( vld      ),
    .rdata_o    ( rdata    ),
    .initDone_o ( initDone )
  );

  tcdmChecker check0 (
    .clk_i        ( clk        ),
    .reset_i      ( reset      ),
    .req_i        ( req        ),
    .addr_i       ( addr       ),
    .we_i         ( we         ),
    .wdata_i      ( wdata      ),
    .be_i         ( be         ),
    .gnt_i        ( gnt        ),
    .vld_i        ( vld        ),
    .rdata_i      ( rdata      ),
    .initDone_i   ( initDone   ),
    .rowDone_i    ( rowDone    ),
    .rowIdx_i     ( rowIdx     ),
    .errCount_o   ( errCount   ),
    .checkCount_o ( checkCount )
  );

  task automatic putSlot(input int r, input int i, input logic isWrite,
                         input tcdmPkg::addr_t a, input tcdmPkg::be_t byteEn);
    tActive[r][i] = 1'b1;
    tWe[r][i]     = isWrite;
    tAddr[r][i]   = a;
    tWdata[r][i]  = $urandom;
    tBe[r][i]     = byteEn;
  endtask

  task automatic buildTable();
    for (int r = 0; r < NumRows; r++) begin
      tActive[r] = '0;
      tWe[r]     = '0;
    end
    // zero check, all four banks of one row per entry
    for (int r = 0; r < SweepRows; r++) begin
      for (int i = 0; i < NumIn; i++) begin
        putSlot(r, i, 1'b0, tcdmPkg::addr_t'(r * 16 + i * 4), 4'hF);
      end
    end
    // partial byte enables, then merged readback
    putSlot(16, 0, 1'b1, 32'h0000_0000, 4'h3);
    putSlot(16, 1, 1'b1, 32'h0000_0014, 4'hC);
    putSlot(16, 2, 1'b1, 32'h0000_0028, 4'h5);
    putSlot(16, 3, 1'b1, 32'h0000_003C, 4'hF);
    putSlot(17, 0, 1'b1, 32'h0000_0000, 4'hC);
    putSlot(17, 1, 1'b0, 32'h0000_0014, 4'hF);
    putSlot(17, 2, 1'b0, 32'h0000_0028, 4'hF);
    putSlot(17, 3, 1'b0, 32'h0000_003C, 4'hF);
    putSlot(18, 0, 1'b0, 32'h0000_0000, 4'hF);
    putSlot(18, 1, 1'b1, 32'h0000_0014, 4'h2);
    // everyone on bank 1
    putSlot(19, 0, 1'b1, 32'h0000_0044, 4'hF);
    putSlot(19, 1, 1'b1, 32'h0000_0054, 4'hF);
    putSlot(19, 2, 1'b1, 32'h0000_0064, 4'hF);
    putSlot(19, 3, 1'b1, 32'h0000_0074, 4'hF);
    putSlot(20, 0, 1'b0, 32'h0000_0074, 4'hF);
    putSlot(20, 1, 1'b0, 32'h0000_0064, 4'hF);
    putSlot(20, 2, 1'b0, 32'h0000_0054, 4'hF);
    putSlot(20, 3, 1'b0, 32'h0000_0044, 4'hF);
    // aliased addresses, only bits 7:0 count
    putSlot(21, 0, 1'b1, 32'hABCD_00C4, 4'hF);
    putSlot(21, 1, 1'b0, 32'h0000_0014, 4'hF);
    putSlot(21, 2, 1'b0, 32'h0000_0038, 4'hF);
    putSlot(21, 3, 1'b1, 32'h0000_0018, 4'h6);
    putSlot(22, 0, 1'b1, 32'h1234_00C4, 4'h1);
    putSlot(22, 1, 1'b0, 32'h0000_00C4, 4'hF);
    putSlot(22, 2, 1'b0, 32'h5500_01C4, 4'hF);
    putSlot(22, 3, 1'b0, 32'hFFFF_FFC4, 4'hF);
    putSlot(23, 0, 1'b0, 32'h9900_00C4, 4'hF);
    putSlot(23, 1, 1'b0, 32'h0000_0018, 4'hF);
    putSlot(23, 3, 1'b0, 32'h7000_0028, 4'hF);
  endtask

  //////////////////////////////////////////////////////////////////////
  // one table row, requests held until granted
  //////////////////////////////////////////////////////////////////////

  task automatic applyRow(input int r);
    logic [NumIn-1:0] pend;
    pend = tActive[r];
    @(posedge clk);
    rowDone <= 1'b0;
    req     <= pend;
    we      <= tWe[r];
    for (int i = 0; i < NumIn; i++) begin
      addr[i]  <= tAddr[r][i];
      wdata[i] <= tWdata[r][i];
      be[i]    <= tBe[r][i];
    end
    while (pend != '0) begin
      @(negedge clk);
      pend = pend & ~gnt;
      @(posedge clk);
      req <= pend;
    end
    // last responses were seen one cycle ago
    @(posedge clk);
    rowIdx  <= r;
    rowDone <= 1'b1;
  endtask

  // watchdog
  always @(posedge clk) begin
    cycleCnt <= cycleCnt + 1;
    if (cycleCnt == MaxCycles) begin
      $display("run timed out after %0d cycles before all rows finished", cycleCnt);
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin
    void'($urandom(71606));
    clk      = 1'b0;
    reset    = 1'b1;
    req      = '0;
    addr     = '0;
    we       = '0;
    wdata    = '0;
    be       = '0;
    rowDone  = 1'b0;
    rowIdx   = 0;
    cycleCnt = 0;
    buildTable();
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    while (!initDone) begin
      @(negedge clk);
    end
    for (int r = 0; r < NumRows; r++) begin
      applyRow(r);
    end
    @(posedge clk);
    rowDone <= 1'b0;
    // checker has finished its last falling-edge pass
    @(posedge clk);
    $display("%0d rows, %0d checks, %0d errors, %0d assertion failures",
             NumRows, checkCount, errCount, dut0.props0.failCount);
    if (errCount == 0 && checkCount > 0 && dut0.props0.failCount == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tests/tcdmChecker.sv */
// TCDM cluster checker
// reference memory and arbiter model, compares what the DUT returns

`timescale 1ns/1ps
`default_nettype none

`include "tcdm_defines.svh"

module tcdmChecker (
  input  wire logic                         clk_i,
  input  wire logic                         reset_i,
  input  wire logic      [`TCDM_NUM_IN-1:0] req_i,
  input  tcdmPkg::addr_t [`TCDM_NUM_IN-1:0] addr_i,
  input  wire logic      [`TCDM_NUM_IN-1:0] we_i,
  input  tcdmPkg::data_t [`TCDM_NUM_IN-1:0] wdata_i,
  input  tcdmPkg::be_t   [`TCDM_NUM_IN-1:0] be_i,
  input  wire logic      [`TCDM_NUM_IN-1:0] gnt_i,
  input  wire logic      [`TCDM_NUM_IN-1:0] vld_i,
  input  tcdmPkg::data_t [`TCDM_NUM_IN-1:0] rdata_i,
  input  wire logic                         initDone_i,
  input  wire logic                         rowDone_i,
  input  int                                rowIdx_i,
  output int                                errCount_o,
  output int                                checkCount_o
);

  localparam int NumIn    = `TCDM_NUM_IN;
  localparam int NumOut   = `TCDM_NUM_OUT;
  localparam int NumBytes = `TCDM_DATA_WIDTH / 8;
  localparam int ByteOff  = `TCDM_BYTE_OFF_WIDTH;
  localparam int SelBits  = $clog2(`TCDM_NUM_OUT);
  localparam int WordBits = SelBits + `TCDM_BANK_ADDR_WIDTH;
  localparam int InitRows = 2 ** `TCDM_BANK_ADDR_WIDTH;

  // word index is addr[7:2], upper bits alias
  tcdmPkg::data_t   refMem [2 ** WordBits];
  tcdmPkg::data_t   pendData [NumIn];
  int               ptr [NumOut];
  logic [NumIn-1:0] pendVld;
  logic [NumIn-1:0] pendRead;
  logic [NumIn-1:0] expGnt;
  logic [NumIn-1:0] wantVec;
  int               initCycles;
  int               rowErrBase;
  int               cand;
  int               winner;
  int               wordIdx;
  bit               initChecked;

  task automatic flagError(input string msg);
    $display("Error at time %0t: %s", $time, msg);
    errCount_o++;
  endtask

  //////////////////////////////////////////////////////////////////////
  // sampled at the falling edge, all inputs settled
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin
    if (reset_i) begin
      for (int w = 0; w < 2 ** WordBits; w++) begin
        refMem[w] = '0;
      end
      for (int b = 0; b < NumOut; b++) begin
        ptr[b] = 0;
      end
      pendVld      = '0;
      pendRead     = '0;
      initCycles   = 0;
      initChecked  = 1'b0;
      rowErrBase   = 0;
      errCount_o   = 0;
      checkCount_o = 0;
    end else begin
      // length of the clearing sweep
      if (!initDone_i) begin
        initCycles++;
      end else if (!initChecked) begin
        initChecked = 1'b1;
        checkCount_o++;
        if (initCycles != InitRows) begin
          flagError($sformatf("init done after %0d cycles, expected %0d",
                              initCycles, InitRows));
        end
      end
      // responses to last cycle's grants
      for (int i = 0; i < NumIn; i++) begin
        checkCount_o++;
        if (vld_i[i] !== pendVld[i]) begin
          flagError($sformatf("port %0d vld %b, expected %b", i, vld_i[i], pendVld[i]));
        end else if (pendRead[i] && rdata_i[i] !== pendData[i]) begin
          flagError($sformatf("port %0d read %h, expected %h", i, rdata_i[i], pendData[i]));
        end
      end
      // round-robin model, one winner per bank
      expGnt = '0;
      for (int b = 0; b < NumOut; b++) begin
        for (int i = 0; i < NumIn; i++) begin
          wantVec[i] = req_i[i] && initDone_i
                       && (int'(addr_i[i][ByteOff +: SelBits]) == b);
        end
        winner = -1;
        for (int k = 0; k < NumIn; k++) begin
          cand = (ptr[b] + k) % NumIn;
          if (winner < 0 && wantVec[cand]) begin
            winner = cand;
          end
        end
        if (winner >= 0) begin
          expGnt[winner] = 1'b1;
          ptr[b]         = (winner + 1) % NumIn;
        end
      end
      checkCount_o++;
      if (gnt_i !== expGnt) begin
        flagError($sformatf("grant %b, expected %b", gnt_i, expGnt));
      end
      // accepted transfers, read before write in the same word
      pendVld  = expGnt;
      pendRead = expGnt & ~we_i;
      for (int i = 0; i < NumIn; i++) begin
        if (expGnt[i]) begin
          wordIdx     = int'(addr_i[i][ByteOff +: WordBits]);
          pendData[i] = refMem[wordIdx];
          if (we_i[i]) begin
            for (int j = 0; j < NumBytes; j++) begin
              if (be_i[i][j]) begin
                refMem[wordIdx][8*j +: 8] = wdata_i[i][8*j +: 8];
              end
            end
          end
        end
      end
      if (rowDone_i) begin
        $display("row %0d finished, %0d errors", rowIdx_i, errCount_o - rowErrBase);
        rowErrBase = errCount_o;
      end
    end
  end

endmodule

`default_nettype wire

/* tests/tcdmCluster_props.sv */
// TCDM cluster protocol assertions
// grant and valid rules, bound into the cluster top

`timescale 1ns/1ps
`default_nettype none

`include "tcdm_defines.svh"

module tcdmClusterProps (
  input wire logic                    clk_i,
  input wire logic                    reset_i,
  input wire logic [`TCDM_NUM_IN-1:0] req_i,
  input wire logic [`TCDM_NUM_IN-1:0] gnt_i,
  input wire logic [`TCDM_NUM_IN-1:0] vld_i,
  input wire logic                    initDone_i
);

  // assertion failures so far
  int failCount = 0;

  // a grant only answers a request
  gntNeedsReq: assert property (@(posedge clk_i) disable iff (reset_i)
    ((gnt_i & ~req_i) == '0))
    else begin
      $error("grant without request");
      failCount++;
    end

  // banks belong to the initializer until done
  gntAfterInit: assert property (@(posedge clk_i) disable iff (reset_i)
    (!initDone_i |-> (gnt_i == '0)))
    else begin
      $error("grant before init done");
      failCount++;
    end

  gntThenVld: assert property (@(posedge clk_i) disable iff (reset_i)
    ((gnt_i != '0) |=> ((vld_i & $past(gnt_i)) == $past(gnt_i))))
    else begin
      $error("grant not followed by vld");
      failCount++;
    end

  // no response nobody asked for
  vldNeedsGnt: assert property (@(posedge clk_i) disable iff (reset_i)
    ((vld_i != '0) |-> ((vld_i & ~$past(gnt_i)) == '0)))
    else begin
      $error("vld without grant in the previous cycle");
      failCount++;
    end

endmodule

bind tcdmCluster tcdmClusterProps props0 (
  .clk_i      ( clk_i      ),
  .reset_i    ( reset_i    ),
  .req_i      ( req_i      ),
  .gnt_i      ( gnt_o      ),
  .vld_i      ( vld_o      ),
  .initDone_i ( initDone_o )
);

`default_nettype wire

/* design/tcdmCluster.sv */
// TCDM cluster top level
// crossbar in front of four banks, plus the reset-time initializer

`timescale 1ns/1ps
`default_nettype none

`include "tcdm_defines.svh"

module tcdmCluster (
  input  wire logic                                clk_i,
  input  wire logic                                reset_i,
  input  wire logic           [`TCDM_NUM_IN-1:0]   req_i,
  input  tcdmPkg::addr_t      [`TCDM_NUM_IN-1:0]   addr_i,
  input  wire logic           [`TCDM_NUM_IN-1:0]   we_i,
  input  tcdmPkg::data_t      [`TCDM_NUM_IN-1:0]   wdata_i,
  input  tcdmPkg::be_t        [`TCDM_NUM_IN-1:0]   be_i,
  output logic                [`TCDM_NUM_IN-1:0]   gnt_o,
  output logic                [`TCDM_NUM_IN-1:0]   vld_o,
  output tcdmPkg::data_t      [`TCDM_NUM_IN-1:0]   rdata_o,
  output logic                                     initDone_o
);

  // crossbar to banks
  logic                        [`TCDM_NUM_OUT-1:0] bankReq;
  logic                        [`TCDM_NUM_OUT-1:0] bankWe;
  tcdmPkg::bankAddr_t          [`TCDM_NUM_OUT-1:0] bankAddr;
  tcdmPkg::data_t              [`TCDM_NUM_OUT-1:0] bankWdata;
  tcdmPkg::be_t                [`TCDM_NUM_OUT-1:0] bankBe;
  tcdmPkg::data_t              [`TCDM_NUM_OUT-1:0] bankRdata;
  // initializer broadcast to all banks
  logic                                            clearEn;
  tcdmPkg::bankAddr_t                              clearRow;

  bankInitFsm i_bankInitFsm (
    .clk_i      ( clk_i      ),
    .reset_i    ( reset_i    ),
    .clearEn_o  ( clearEn    ),
    .clearRow_o ( clearRow   ),
    .initDone_o ( initDone_o )
  );

  tcdmXbar i_tcdmXbar (
    .clk_i       ( clk_i      ),
    .reset_i     ( reset_i    ),
    .initDone_i  ( initDone_o ),
    .req_i       ( req_i      ),
    .addr_i      ( addr_i     ),
    .we_i        ( we_i       ),
    .wdata_i     ( wdata_i    ),
    .be_i        ( be_i       ),
    .gnt_o       ( gnt_o      ),
    .vld_o       ( vld_o      ),
    .rdata_o     ( rdata_o    ),
    .bankReq_o   ( bankReq    ),
    .bankWe_o    ( bankWe     ),
    .bankAddr_o  ( bankAddr   ),
    .bankWdata_o ( bankWdata  ),
    .bankBe_o    ( bankBe     ),
    .bankRdata_i ( bankRdata  )
  );

  // word-interleaved banks
  for (genvar b = 0; b < `TCDM_NUM_OUT; b++) begin : gen_banks
    tcdmBank i_tcdmBank (
      .clk_i      ( clk_i        ),
      .reset_i    ( reset_i      ),
      .req_i      ( bankReq[b]   ),
      .we_i       ( bankWe[b]    ),
      .addr_i     ( bankAddr[b]  ),
      .wdata_i    ( bankWdata[b] ),
      .be_i       ( bankBe[b]    ),
      .clearEn_i  ( clearEn      ),
      .clearRow_i ( clearRow     ),
      .rdata_o    ( bankRdata[b] )
    );
  end

endmodule

`default_nettype wire

/* design/tcdmXbar.sv */
// TCDM full crossbar
// address decode, per-bank round-robin arbitration, routing and
// response return one cycle after the grant

`timescale 1ns/1ps
`default_nettype none

`include "tcdm_defines.svh"

module tcdmXbar (
  input  wire logic                                    clk_i,
  input  wire logic                                    reset_i,
  input  wire logic                                    initDone_i,
  // initiator side
  input  wire logic               [`TCDM_NUM_IN-1:0]   req_i,
  input  tcdmPkg::addr_t          [`TCDM_NUM_IN-1:0]   addr_i,
  input  wire logic               [`TCDM_NUM_IN-1:0]   we_i,
  input  tcdmPkg::data_t          [`TCDM_NUM_IN-1:0]   wdata_i,
  input  tcdmPkg::be_t            [`TCDM_NUM_IN-1:0]   be_i,
  output logic                    [`TCDM_NUM_IN-1:0]   gnt_o,
  output logic                    [`TCDM_NUM_IN-1:0]   vld_o,
  output tcdmPkg::data_t          [`TCDM_NUM_IN-1:0]   rdata_o,
  // bank side
  output logic                    [`TCDM_NUM_OUT-1:0]  bankReq_o,
  output logic                    [`TCDM_NUM_OUT-1:0]  bankWe_o,
  output tcdmPkg::bankAddr_t      [`TCDM_NUM_OUT-1:0]  bankAddr_o,
  output tcdmPkg::data_t          [`TCDM_NUM_OUT-1:0]  bankWdata_o,
  output tcdmPkg::be_t            [`TCDM_NUM_OUT-1:0]  bankBe_o,
  input  tcdmPkg::data_t          [`TCDM_NUM_OUT-1:0]  bankRdata_i
);

  localparam int unsigned NumIn    = `TCDM_NUM_IN;
  localparam int unsigned NumOut   = `TCDM_NUM_OUT;
  localparam int unsigned SelWidth = $bits(tcdmPkg::bankSel_t);
  localparam int unsigned RowLsb   = `TCDM_BYTE_OFF_WIDTH + SelWidth;
  localparam int unsigned IdxWidth = $clog2(NumIn);

  tcdmPkg::bankSel_t  [NumIn-1:0]                bankSel;
  tcdmPkg::bankAddr_t [NumIn-1:0]                rowAddr;
  // per bank: which initiators want it, which one got it
  logic               [NumOut-1:0][NumIn-1:0]    bankReqVec;
  logic               [NumOut-1:0][NumIn-1:0]    bankGnt;
  logic               [NumOut-1:0][IdxWidth-1:0] winIdx;
  // response bookkeeping, one slot per bank
  logic               [NumOut-1:0][IdxWidth-1:0] winIdxQ;
  logic               [NumOut-1:0]               rspVldQ;

  //////////////////////////////////////////////////////////////////////
  // address decode
  //////////////////////////////////////////////////////////////////////

  // bits above the row field are dropped, so addresses alias
  for (genvar i = 0; i < NumIn; i++) begin : gen_decode
    assign bankSel[i] = addr_i[i][`TCDM_BYTE_OFF_WIDTH +: SelWidth];
    assign rowAddr[i] = addr_i[i][RowLsb +: `TCDM_BANK_ADDR_WIDTH];
  end

  //////////////////////////////////////////////////////////////////////
  // per-bank arbitration and routing
  //////////////////////////////////////////////////////////////////////

  for (genvar b = 0; b < NumOut; b++) begin : gen_bank
    // nothing reaches the arbiter before init is done
    for (genvar i = 0; i < NumIn; i++) begin : gen_reqVec
      assign bankReqVec[b][i] = req_i[i] && initDone_i
                                && (bankSel[i] == tcdmPkg::bankSel_t'(b));
    end

    rrArbiter #(
      .NumReq  ( NumIn         )
    ) i_rrArbiter (
      .clk_i   ( clk_i         ),
      .reset_i ( reset_i       ),
      .req_i   ( bankReqVec[b] ),
      .gnt_o   ( bankGnt[b]    )
    );

    // one-hot to index
    always_comb begin
      winIdx[b] = '0;
      for (int unsigned i = 0; i < NumIn; i++) begin
        if (bankGnt[b][i]) begin
          winIdx[b] = IdxWidth'(i);
        end
      end
    end

    // winner payload to the bank
    assign bankReq_o[b]   = |bankGnt[b];
    assign bankWe_o[b]    = we_i[winIdx[b]];
    assign bankAddr_o[b]  = rowAddr[winIdx[b]];
    assign bankWdata_o[b] = wdata_i[winIdx[b]];
    assign bankBe_o[b]    = be_i[winIdx[b]];
  end

  // an initiator targets one bank, so at most one term is set
  always_comb begin
    gnt_o = '0;
    for (int unsigned b = 0; b < NumOut; b++) begin
      gnt_o = gnt_o | bankGnt[b];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // response path
  //////////////////////////////////////////////////////////////////////

  // write responses too, so every accepted request gets a valid
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rspVldQ <= '0;
    end else begin
      rspVldQ <= bankReq_o;
    end
  end

  always_ff @(posedge clk_i) begin
    winIdxQ <= winIdx;
  end

  // steer bank data back to whoever was granted last cycle
  always_comb begin
    vld_o   = '0;
    rdata_o = '0;
    for (int unsigned b = 0; b < NumOut; b++) begin
      if (rspVldQ[b]) begin
        vld_o[winIdxQ[b]]   = 1'b1;
        rdata_o[winIdxQ[b]] = bankRdata_i[b];
      end
    end
  end

endmodule

`default_nettype wire

/* design/bankInitFsm.sv */
// Bank initializer
// sweeps every row once after reset, then flags done

`timescale 1ns/1ps
`default_nettype none

`include "tcdm_defines.svh"

module bankInitFsm (
  input  wire logic          clk_i,
  input  wire logic          reset_i,
  output logic               clearEn_o,
  output tcdmPkg::bankAddr_t clearRow_o,
  output logic               initDone_o
);

  localparam tcdmPkg::bankAddr_t LastRow = tcdmPkg::bankAddr_t'((2 ** `TCDM_BANK_ADDR_WIDTH) - 1);

  tcdmPkg::initState_e stateQ;
  tcdmPkg::initState_e stateD;
  tcdmPkg::bankAddr_t  rowQ;
  tcdmPkg::bankAddr_t  rowD;

  //////////////////////////////////////////////////////////////////////
  // next state
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    stateD = stateQ;
    rowD   = rowQ;
    case (stateQ)
      tcdmPkg::InitClear: begin
        // one row per cycle
        rowD = rowQ + 1'b1;
        if (rowQ == LastRow) begin
          stateD = tcdmPkg::InitReady;
        end
      end
      // stays here until the next reset
      tcdmPkg::InitReady: begin
        rowD = rowQ;
      end
      default: begin
        stateD = tcdmPkg::InitClear;
        rowD   = '0;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      stateQ <= tcdmPkg::InitClear;
      rowQ   <= '0;
    end else begin
      stateQ <= stateD;
      rowQ   <= rowD;
    end
  end

  // outputs decoded from state
  assign clearEn_o  = (stateQ == tcdmPkg::InitClear);
  assign clearRow_o = rowQ;
  assign initDone_o = (stateQ == tcdmPkg::InitReady);

endmodule

`default_nettype wire

/* design/tcdmBank.sv */
// TCDM memory bank
// one word wide, byte-enabled writes, row clear, 1-cycle read

`timescale 1ns/1ps
`default_nettype none

`include "tcdm_defines.svh"

module tcdmBank (
  input  wire logic               clk_i,
  input  wire logic               reset_i,
  input  wire logic               req_i,
  input  wire logic               we_i,
  input  tcdmPkg::bankAddr_t      addr_i,
  input  tcdmPkg::data_t          wdata_i,
  input  tcdmPkg::be_t            be_i,
  input  wire logic               clearEn_i,
  input  tcdmPkg::bankAddr_t      clearRow_i,
  output tcdmPkg::data_t          rdata_o
);

  localparam int unsigned NumRows  = 2 ** `TCDM_BANK_ADDR_WIDTH;
  localparam int unsigned NumBytes = `TCDM_DATA_WIDTH / 8;

  // storage array
  tcdmPkg::data_t mem [NumRows];

  // write port
  always_ff @(posedge clk_i) begin
    if (clearEn_i) begin
      // init sweep owns the array, crossbar is masked meanwhile
      mem[clearRow_i] <= '0;
    end else if (req_i && we_i) begin
      for (int unsigned b = 0; b < NumBytes; b++) begin
        // only enabled lanes change
        if (be_i[b]) begin
          mem[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

  // read port, data shows up the cycle after the request
  // on a write this returns the old word, nobody looks at it
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rdata_o <= '0;
    end else if (req_i) begin
      rdata_o <= mem[addr_i];
    end
  end

endmodule

`default_nettype wire

/* design/rrArbiter.sv */
// Round-robin arbiter
// combinational one-hot grant, rotating priority pointer

`timescale 1ns/1ps
`default_nettype none

module rrArbiter #(
  parameter int unsigned NumReq = 4
) (
  input  wire logic              clk_i,
  input  wire logic              reset_i,
  input  wire logic [NumReq-1:0] req_i,
  output logic      [NumReq-1:0] gnt_o
);

  localparam int unsigned IdxWidth = (NumReq > 1) ? $clog2(NumReq) : 1;

  // pointer marks the requester with highest priority
  logic [IdxWidth-1:0] ptrQ;
  logic [IdxWidth-1:0] ptrD;
  logic [IdxWidth-1:0] winIdx;
  logic                anyGnt;

  //////////////////////////////////////////////////////////////////////
  // grant search
  //////////////////////////////////////////////////////////////////////

  // walk upward from the pointer, wrapping at NumReq
  always_comb begin
    int unsigned cand;
    gnt_o  = '0;
    anyGnt = 1'b0;
    winIdx = ptrQ;
    for (int unsigned i = 0; i < NumReq; i++) begin
      cand = (int'(ptrQ) + i) % NumReq;
      // first hit wins, later ones ignored
      if (!anyGnt && req_i[cand]) begin
        anyGnt      = 1'b1;
        winIdx      = IdxWidth'(cand);
        gnt_o[cand] = 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // pointer update
  //////////////////////////////////////////////////////////////////////

  // winner drops to lowest priority
  always_comb begin
    ptrD = ptrQ;
    if (anyGnt) begin
      if (winIdx == IdxWidth'(NumReq - 1)) begin
        ptrD = '0;
      end else begin
        ptrD = winIdx + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ptrQ <= '0;
    end else begin
      ptrQ <= ptrD;
    end
  end

endmodule

`default_nettype wire

/* design/tcdmPkg.sv */
// TCDM cluster types
// width typedefs and the bank initializer states

`default_nettype none

`include "tcdm_defines.svh"

package tcdmPkg;

  // initiator byte address
  typedef logic [`TCDM_ADDR_WIDTH-1:0] addr_t;

  // one data word
  typedef logic [`TCDM_DATA_WIDTH-1:0] data_t;

  // one enable per byte lane
  typedef logic [`TCDM_DATA_WIDTH/8-1:0] be_t;

  // bank index taken from the address
  typedef logic [$clog2(`TCDM_NUM_OUT)-1:0] bankSel_t;

  // row inside a bank
  typedef logic [`TCDM_BANK_ADDR_WIDTH-1:0] bankAddr_t;

  // bank initializer
  typedef enum logic {
    InitClear,
    InitReady
  } initState_e;

endpackage

`default_nettype wire

/* design/tcdm_defines.svh */
// TCDM cluster configuration macros
// port counts and widths shared by RTL and testbench

`ifndef TCDM_DEFINES_SVH
`define TCDM_DEFINES_SVH

// initiator ports into the crossbar
`define TCDM_NUM_IN 4

// word-interleaved memory banks
`define TCDM_NUM_OUT 4

// byte address width on the initiator side
`define TCDM_ADDR_WIDTH 32

// one memory word
`define TCDM_DATA_WIDTH 32

// low address bits that select a byte inside a word
`define TCDM_BYTE_OFF_WIDTH 2

// row bits per bank, 16 rows
`define TCDM_BANK_ADDR_WIDTH 4

`endif
